//--- Makefile
VERILATOR ?= verilator
TOP       ?= issue_core_tb
RTL_TOP   ?= issue_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
SEED_LOG  ?= sim.log
VFLAGS    ?=
LINT_WARN ?= -Wall
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_WARN) $(VFLAGS) --top-module $(RTL_TOP) \
		source/cpu_pkg.sv source/uop_decode.sv source/prf.sv \
		source/alu_execute.sv source/cdb_result.sv source/issue_core.sv
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(SEED_LOG)
	@grep -q "$(PASS_MSG)" $(SEED_LOG) || \
		(echo "Pass message not found in $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

//--- dv/issue_core_tb.sv
module issue_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int          RANDOM_CYCLES  = 2000;
    localparam int          TIMEOUT_CYCLES = 2100;
    localparam logic [31:0] LFSR_SEED      = 32'hbc94_7adc;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic clk;
    logic rst;

    logic    [CDB_WIDTH-1:0] issue_valid;
    opcode_t [CDB_WIDTH-1:0] issue_opcode;
    phy_t    [CDB_WIDTH-1:0] issue_rs1;
    phy_t    [CDB_WIDTH-1:0] issue_rs2;
    phy_t    [CDB_WIDTH-1:0] issue_rd;
    imm_t    [CDB_WIDTH-1:0] issue_imm;

    logic    [CDB_WIDTH-1:0] cdb_valid;
    phy_t    [CDB_WIDTH-1:0] cdb_rd;
    word_t   [CDB_WIDTH-1:0] cdb_value;

    // Reference register file and the CDB entries expected in the current cycle
    word_t                model_regs [PRF_DEPTH];
    logic [CDB_WIDTH-1:0] exp_valid;
    phy_t                 exp_rd     [CDB_WIDTH];
    word_t                exp_value  [CDB_WIDTH];

    logic [31:0] lfsr = LFSR_SEED;
    int          errors = 0;
    int          cycle_count = 0;
    string       test_name = "reset";

    issue_core issue_core_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_opcode (issue_opcode),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rd     (issue_rd),
        .issue_imm    (issue_imm),
        .cdb_valid    (cdb_valid),
        .cdb_rd       (cdb_rd),
        .cdb_value    (cdb_value)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Mostly the low 8 registers so that dependencies are frequent
    function automatic phy_t pick_reg();
        if (rand_bits(2) != 0) begin
            return phy_t'(rand_bits(3));
        end
        return phy_t'(rand_bits(PHY_W));
    endfunction

    function automatic word_t read_reg(input phy_t r);
        word_t v;
        if (r == '0) begin
            return '0;
        end
        v = model_regs[r];
        for (int l = 0; l < CDB_WIDTH; l++) begin
            if (exp_valid[l] && (exp_rd[l] == r)) begin
                v = exp_value[l];
            end
        end
        return v;
    endfunction

    function automatic word_t model_result(input opcode_t op, input word_t a,
                                           input word_t b, input imm_t imm);
        word_t immx;
        immx = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return word_t'($signed(a) >>> b[4:0]);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_ADDI: return a + immx;
            OP_ANDI: return a & immx;
            OP_ORI:  return a | immx;
            OP_XORI: return a ^ immx;
            OP_LUI:  return {imm, 20'b0};
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %s %s expected %h actual %h", test_name, name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_cdb();
        for (int l = 0; l < CDB_WIDTH; l++) begin
            if (exp_valid[l] !== cdb_valid[l]) begin
                if (exp_valid[l]) begin
                    $display("%s: lane %0d gave no CDB pulse for p%0d", test_name, l, exp_rd[l]);
                end else begin
                    $display("%s: lane %0d gave an unexpected CDB pulse", test_name, l);
                end
                errors++;
            end else if (exp_valid[l]) begin
                check_value($sformatf("cdb_rd[%0d]", l), word_t'(exp_rd[l]),
                            word_t'(cdb_rd[l]));
                check_value($sformatf("cdb_value[%0d]", l), exp_value[l], cdb_value[l]);
            end
        end
    endtask

    task automatic clear_uops();
        issue_valid  = '0;
        issue_opcode = '0;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_rd     = '0;
        issue_imm    = '0;
    endtask

    task automatic set_uop(input int lane, input opcode_t op, input phy_t rs1,
                           input phy_t rs2, input phy_t rd, input imm_t imm);
        issue_valid[lane]  = 1'b1;
        issue_opcode[lane] = op;
        issue_rs1[lane]    = rs1;
        issue_rs2[lane]    = rs2;
        issue_rd[lane]     = rd;
        issue_imm[lane]    = imm;
    endtask

    task automatic random_uops();
        for (int l = 0; l < CDB_WIDTH; l++) begin
            issue_valid[l]  = (rand_bits(3) != 0);
            issue_opcode[l] = opcode_t'(rand_bits(OP_W));
            issue_rs1[l]    = pick_reg();
            issue_rs2[l]    = pick_reg();
            issue_rd[l]     = pick_reg();
            issue_imm[l]    = imm_t'(rand_bits(IMM_W));
        end
    endtask

    // Check this cycle's CDB, predict the issued micro-ops, then move to the next cycle
    task automatic run_cycle();
        logic [CDB_WIDTH-1:0] nxt_valid;
        phy_t                 nxt_rd    [CDB_WIDTH];
        word_t                nxt_value [CDB_WIDTH];
        compare_cdb();
        for (int l = 0; l < CDB_WIDTH; l++) begin
            nxt_valid[l] = issue_valid[l] && (issue_opcode[l] != OP_NOP) && (issue_rd[l] != '0);
            nxt_rd[l]    = issue_rd[l];
            nxt_value[l] = model_result(issue_opcode[l], read_reg(issue_rs1[l]),
                                        read_reg(issue_rs2[l]), issue_imm[l]);
        end
        for (int l = 0; l < CDB_WIDTH; l++) begin
            for (int h = l + 1; h < CDB_WIDTH; h++) begin
                if (nxt_valid[h] && (nxt_rd[h] == nxt_rd[l])) begin
                    nxt_valid[l] = 1'b0;
                end
            end
        end
        for (int l = 0; l < CDB_WIDTH; l++) begin
            if (exp_valid[l] && (exp_rd[l] != '0)) begin
                model_regs[exp_rd[l]] = exp_value[l];
            end
        end
        for (int l = 0; l < CDB_WIDTH; l++) begin
            exp_valid[l] = nxt_valid[l];
            exp_rd[l]    = nxt_rd[l];
            exp_value[l] = nxt_value[l];
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        rst = 1'b1;
        clear_uops();
        exp_valid = '0;
        for (int i = 0; i < PRF_DEPTH; i++) begin
            model_regs[i] = '0;
        end
        for (int l = 0; l < CDB_WIDTH; l++) begin
            exp_rd[l]    = '0;
            exp_value[l] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        test_name = "idle_after_reset";
        repeat (3) run_cycle();
        set_uop(0, OP_ADD, 6'd3, 6'd4, 6'd5, '0);
        run_cycle();
        clear_uops();
        check_value("unwritten_read", 32'h0, cdb_value[0]);

        test_name = "opcodes";
        set_uop(0, OP_ADDI, 6'd0, 6'd0, 6'd1, 12'h800);
        set_uop(1, OP_ADDI, 6'd0, 6'd0, 6'd2, 12'h7ff);
        run_cycle();
        check_value("addi_neg", 32'hffff_f800, cdb_value[0]);
        check_value("addi_pos", 32'h0000_07ff, cdb_value[1]);
        clear_uops();
        set_uop(0, OP_LUI, 6'd0, 6'd0, 6'd3, 12'habc);
        run_cycle();
        check_value("lui", 32'habc0_0000, cdb_value[0]);
        for (int op = 0; op < 16; op++) begin
            set_uop(0, opcode_t'(op), 6'd1, 6'd2, phy_t'(8 + op), 12'h9a5);
            set_uop(1, opcode_t'(op), 6'd2, 6'd1, phy_t'(24 + op), 12'h9a5);
            run_cycle();
        end

        test_name = "bypass";
        set_uop(0, OP_ADDI, 6'd0, 6'd0, 6'd10, 12'h123);
        set_uop(1, OP_ADDI, 6'd0, 6'd0, 6'd11, 12'h456);
        run_cycle();
        set_uop(0, OP_ADD, 6'd11, 6'd1, 6'd12, '0);
        set_uop(1, OP_SUB, 6'd2, 6'd10, 6'd13, '0);
        run_cycle();
        check_value("bypass_rs1_cross", 32'hffff_fc56, cdb_value[0]);
        check_value("bypass_rs2_cross", 32'h0000_06dc, cdb_value[1]);
        set_uop(0, OP_XOR, 6'd1, 6'd12, 6'd14, '0);
        set_uop(1, OP_OR, 6'd13, 6'd2, 6'd15, '0);
        run_cycle();
        check_value("bypass_rs2_same", 32'h0000_0456, cdb_value[0]);
        check_value("bypass_rs1_same", 32'h0000_07ff, cdb_value[1]);

        test_name = "reg_zero";
        set_uop(0, OP_ADDI, 6'd0, 6'd0, 6'd0, 12'h055);
        set_uop(1, OP_NOP, 6'd1, 6'd2, 6'd5, 12'h055);
        run_cycle();
        check_value("no_pulse", 32'h0, word_t'(cdb_valid));
        set_uop(0, OP_ADD, 6'd0, 6'd0, 6'd16, '0);
        set_uop(1, OP_ORI, 6'd0, 6'd0, 6'd17, '0);
        run_cycle();
        check_value("p0_read_0", 32'h0, cdb_value[0]);
        check_value("p0_read_1", 32'h0, cdb_value[1]);

        test_name = "same_rd";
        set_uop(0, OP_ADDI, 6'd0, 6'd0, 6'd20, 12'h111);
        set_uop(1, OP_ADDI, 6'd0, 6'd0, 6'd20, 12'h222);
        run_cycle();
        check_value("same_rd_valid", 32'h2, word_t'(cdb_valid));
        clear_uops();
        set_uop(0, OP_ADD, 6'd20, 6'd0, 6'd21, '0);
        run_cycle();
        check_value("same_rd_bypass", 32'h0000_0222, cdb_value[0]);
        clear_uops();
        set_uop(1, OP_ADD, 6'd0, 6'd20, 6'd22, '0);
        run_cycle();
        check_value("same_rd_stored", 32'h0000_0222, cdb_value[1]);

        test_name = "random";
        repeat (RANDOM_CYCLES) begin
            random_uops();
            run_cycle();
        end
        clear_uops();
        run_cycle();

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- source/alu_execute.sv
module alu_execute (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic             [cpu_pkg::CDB_WIDTH-1:0]   issue_valid,
    input  cpu_pkg::phy_t    [cpu_pkg::CDB_WIDTH-1:0]   issue_rd,
    input  cpu_pkg::imm_t    [cpu_pkg::CDB_WIDTH-1:0]   issue_imm,

    input  cpu_pkg::alu_op_t [cpu_pkg::CDB_WIDTH-1:0]   alu_op,
    input  logic             [cpu_pkg::CDB_WIDTH-1:0]   use_imm,
    input  logic             [cpu_pkg::CDB_WIDTH-1:0]   writes_rd,

    input  cpu_pkg::word_t   [cpu_pkg::CDB_WIDTH-1:0]   rs1_value,
    input  cpu_pkg::word_t   [cpu_pkg::CDB_WIDTH-1:0]   rs2_value,

    output logic             [cpu_pkg::CDB_WIDTH-1:0]   ex_valid,
    output cpu_pkg::phy_t    [cpu_pkg::CDB_WIDTH-1:0]   ex_rd,
    output cpu_pkg::word_t   [cpu_pkg::CDB_WIDTH-1:0]   ex_value
);
    import cpu_pkg::*;

    word_t [CDB_WIDTH-1:0] imm_value;
    word_t [CDB_WIDTH-1:0] op_b;
    word_t [CDB_WIDTH-1:0] result;

    always_comb begin
        for (int i = 0; i < CDB_WIDTH; i++) begin
            // LUI is the only user of PASSB
            if (alu_op[i] == ALU_PASSB) begin
                imm_value[i] = {issue_imm[i], {(XLEN-IMM_W){1'b0}}};
            end else begin
                imm_value[i] = {{(XLEN-IMM_W){issue_imm[i][IMM_W-1]}}, issue_imm[i]};
            end

            op_b[i] = use_imm[i] ? imm_value[i] : rs2_value[i];

            case (alu_op[i])
                ALU_ADD:   result[i] = rs1_value[i] + op_b[i];
                ALU_SUB:   result[i] = rs1_value[i] - op_b[i];
                ALU_AND:   result[i] = rs1_value[i] & op_b[i];
                ALU_OR:    result[i] = rs1_value[i] | op_b[i];
                ALU_XOR:   result[i] = rs1_value[i] ^ op_b[i];
                ALU_SLL:   result[i] = rs1_value[i] << op_b[i][SHAMT_W-1:0];
                ALU_SRL:   result[i] = rs1_value[i] >> op_b[i][SHAMT_W-1:0];
                ALU_SRA:   result[i] = word_t'($signed(rs1_value[i]) >>> op_b[i][SHAMT_W-1:0]);
                ALU_SLT:   result[i] = {31'b0, $signed(rs1_value[i]) < $signed(op_b[i])};
                ALU_SLTU:  result[i] = {31'b0, rs1_value[i] < op_b[i]};
                ALU_PASSB: result[i] = op_b[i];
                default:   result[i] = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= '0;
        end else begin
            ex_valid <= issue_valid & writes_rd;
        end
    end

    // Destination and result travel with ex_valid
    always_ff @(posedge clk) begin
        ex_rd    <= issue_rd;
        ex_value <= result;
    end

endmodule

//--- source/cdb_result.sv
module cdb_result (
    input  logic           [cpu_pkg::CDB_WIDTH-1:0] ex_valid,
    input  cpu_pkg::phy_t  [cpu_pkg::CDB_WIDTH-1:0] ex_rd,
    input  cpu_pkg::word_t [cpu_pkg::CDB_WIDTH-1:0] ex_value,

    output logic           [cpu_pkg::CDB_WIDTH-1:0] cdb_valid,
    output cpu_pkg::phy_t  [cpu_pkg::CDB_WIDTH-1:0] cdb_rd,
    output cpu_pkg::word_t [cpu_pkg::CDB_WIDTH-1:0] cdb_value
);
    import cpu_pkg::*;

    // Lane i is overridden by any valid higher lane with the same rd
    logic [CDB_WIDTH-1:0] shadowed;

    always_comb begin
        for (int i = 0; i < CDB_WIDTH; i++) begin
            shadowed[i] = 1'b0;
            for (int j = i + 1; j < CDB_WIDTH; j++) begin
                if (ex_valid[j] && (ex_rd[j] == ex_rd[i])) begin
                    shadowed[i] = 1'b1;
                end
            end
        end
    end

    // At most one producer per register per cycle
    assign cdb_valid = ex_valid & ~shadowed;
    assign cdb_rd    = ex_rd;
    assign cdb_value = ex_value;

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN      = 32;
    localparam int PRF_DEPTH = 64;
    localparam int PHY_W     = 6;
    localparam int CDB_WIDTH = 2;
    localparam int IMM_W     = 12;
    localparam int OP_W      = 4;
    localparam int SHAMT_W   = 5;

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [PHY_W-1:0] phy_t;
    typedef logic [OP_W-1:0]  opcode_t;
    typedef logic [IMM_W-1:0] imm_t;
    typedef logic [3:0]       alu_op_t;

    // Micro-op opcodes
    localparam opcode_t OP_NOP  = 4'h0;
    localparam opcode_t OP_ADD  = 4'h1;
    localparam opcode_t OP_SUB  = 4'h2;
    localparam opcode_t OP_AND  = 4'h3;
    localparam opcode_t OP_OR   = 4'h4;
    localparam opcode_t OP_XOR  = 4'h5;
    localparam opcode_t OP_SLL  = 4'h6;
    localparam opcode_t OP_SRL  = 4'h7;
    localparam opcode_t OP_SRA  = 4'h8;
    localparam opcode_t OP_SLT  = 4'h9;
    localparam opcode_t OP_SLTU = 4'ha;
    localparam opcode_t OP_ADDI = 4'hb;
    localparam opcode_t OP_ANDI = 4'hc;
    localparam opcode_t OP_ORI  = 4'hd;
    localparam opcode_t OP_XORI = 4'he;
    localparam opcode_t OP_LUI  = 4'hf;

    // ALU operations
    localparam alu_op_t ALU_ADD   = 4'h0;
    localparam alu_op_t ALU_SUB   = 4'h1;
    localparam alu_op_t ALU_AND   = 4'h2;
    localparam alu_op_t ALU_OR    = 4'h3;
    localparam alu_op_t ALU_XOR   = 4'h4;
    localparam alu_op_t ALU_SLL   = 4'h5;
    localparam alu_op_t ALU_SRL   = 4'h6;
    localparam alu_op_t ALU_SRA   = 4'h7;
    localparam alu_op_t ALU_SLT   = 4'h8;
    localparam alu_op_t ALU_SLTU  = 4'h9;
    // Forwards operand B untouched
    localparam alu_op_t ALU_PASSB = 4'ha;

endpackage

//--- source/issue_core.sv
module issue_core (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic             [cpu_pkg::CDB_WIDTH-1:0]   issue_valid,
    input  cpu_pkg::opcode_t [cpu_pkg::CDB_WIDTH-1:0]   issue_opcode,
    input  cpu_pkg::phy_t    [cpu_pkg::CDB_WIDTH-1:0]   issue_rs1,
    input  cpu_pkg::phy_t    [cpu_pkg::CDB_WIDTH-1:0]   issue_rs2,
    input  cpu_pkg::phy_t    [cpu_pkg::CDB_WIDTH-1:0]   issue_rd,
    input  cpu_pkg::imm_t    [cpu_pkg::CDB_WIDTH-1:0]   issue_imm,

    output logic             [cpu_pkg::CDB_WIDTH-1:0]   cdb_valid,
    output cpu_pkg::phy_t    [cpu_pkg::CDB_WIDTH-1:0]   cdb_rd,
    output cpu_pkg::word_t   [cpu_pkg::CDB_WIDTH-1:0]   cdb_value
);
    import cpu_pkg::*;

    // Decode to execute
    alu_op_t [CDB_WIDTH-1:0] alu_op;
    logic    [CDB_WIDTH-1:0] use_imm;
    logic    [CDB_WIDTH-1:0] writes_rd;

    // Register read to execute
    word_t   [CDB_WIDTH-1:0] rs1_value;
    word_t   [CDB_WIDTH-1:0] rs2_value;

    // Execute to result
    logic    [CDB_WIDTH-1:0] ex_valid;
    phy_t    [CDB_WIDTH-1:0] ex_rd;
    word_t   [CDB_WIDTH-1:0] ex_value;

    uop_decode uop_decode_i (
        .issue_valid  (issue_valid),
        .issue_opcode (issue_opcode),
        .issue_rd     (issue_rd),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .writes_rd    (writes_rd)
    );

    // CDB outputs loop back as write and bypass ports
    prf prf_i (
        .clk       (clk),
        .rst       (rst),
        .rs1       (issue_rs1),
        .rs2       (issue_rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .cdb_valid (cdb_valid),
        .cdb_rd    (cdb_rd),
        .cdb_value (cdb_value)
    );

    alu_execute alu_execute_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_rd    (issue_rd),
        .issue_imm   (issue_imm),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .writes_rd   (writes_rd),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_value    (ex_value)
    );

    cdb_result cdb_result_i (
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_value  (ex_value),
        .cdb_valid (cdb_valid),
        .cdb_rd    (cdb_rd),
        .cdb_value (cdb_value)
    );

endmodule

//--- source/prf.sv
module prf (
    input  logic                                      clk,
    input  logic                                      rst,

    input  cpu_pkg::phy_t  [cpu_pkg::CDB_WIDTH-1:0]   rs1,
    input  cpu_pkg::phy_t  [cpu_pkg::CDB_WIDTH-1:0]   rs2,
    output cpu_pkg::word_t [cpu_pkg::CDB_WIDTH-1:0]   rs1_value,
    output cpu_pkg::word_t [cpu_pkg::CDB_WIDTH-1:0]   rs2_value,

    input  logic           [cpu_pkg::CDB_WIDTH-1:0]   cdb_valid,
    input  cpu_pkg::phy_t  [cpu_pkg::CDB_WIDTH-1:0]   cdb_rd,
    input  cpu_pkg::word_t [cpu_pkg::CDB_WIDTH-1:0]   cdb_value
);
    import cpu_pkg::*;

    word_t prf_data [PRF_DEPTH];

    // Duplicate destinations are already removed on the CDB
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PRF_DEPTH; i++) begin
                prf_data[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CDB_WIDTH; i++) begin
                if (cdb_valid[i] && (cdb_rd[i] != '0)) begin
                    prf_data[cdb_rd[i]] <= cdb_value[i];
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < CDB_WIDTH; j++) begin
            rs1_value[j] = prf_data[rs1[j]];
            rs2_value[j] = prf_data[rs2[j]];

            // Ascending scan so the highest matching lane wins
            for (int i = 0; i < CDB_WIDTH; i++) begin
                if (cdb_valid[i] && (cdb_rd[i] == rs1[j])) begin
                    rs1_value[j] = cdb_value[i];
                end
                if (cdb_valid[i] && (cdb_rd[i] == rs2[j])) begin
                    rs2_value[j] = cdb_value[i];
                end
            end

            // p0 reads as zero regardless of the CDB
            if (rs1[j] == '0) begin
                rs1_value[j] = '0;
            end
            if (rs2[j] == '0) begin
                rs2_value[j] = '0;
            end
        end
    end

endmodule

//--- source/uop_decode.sv
module uop_decode (
    input  logic             [cpu_pkg::CDB_WIDTH-1:0] issue_valid,
    input  cpu_pkg::opcode_t [cpu_pkg::CDB_WIDTH-1:0] issue_opcode,
    input  cpu_pkg::phy_t    [cpu_pkg::CDB_WIDTH-1:0] issue_rd,

    output cpu_pkg::alu_op_t [cpu_pkg::CDB_WIDTH-1:0] alu_op,
    output logic             [cpu_pkg::CDB_WIDTH-1:0] use_imm,
    output logic             [cpu_pkg::CDB_WIDTH-1:0] writes_rd
);
    import cpu_pkg::*;

    // Set for opcodes that produce a result
    logic [CDB_WIDTH-1:0] has_result;

    always_comb begin
        for (int i = 0; i < CDB_WIDTH; i++) begin
            alu_op[i]     = ALU_ADD;
            use_imm[i]    = 1'b0;
            has_result[i] = 1'b1;

            case (issue_opcode[i])
                OP_ADD:  alu_op[i] = ALU_ADD;
                OP_SUB:  alu_op[i] = ALU_SUB;
                OP_AND:  alu_op[i] = ALU_AND;
                OP_OR:   alu_op[i] = ALU_OR;
                OP_XOR:  alu_op[i] = ALU_XOR;
                OP_SLL:  alu_op[i] = ALU_SLL;
                OP_SRL:  alu_op[i] = ALU_SRL;
                OP_SRA:  alu_op[i] = ALU_SRA;
                OP_SLT:  alu_op[i] = ALU_SLT;
                OP_SLTU: alu_op[i] = ALU_SLTU;
                OP_ADDI: begin
                    alu_op[i]  = ALU_ADD;
                    use_imm[i] = 1'b1;
                end
                OP_ANDI: begin
                    alu_op[i]  = ALU_AND;
                    use_imm[i] = 1'b1;
                end
                OP_ORI: begin
                    alu_op[i]  = ALU_OR;
                    use_imm[i] = 1'b1;
                end
                OP_XORI: begin
                    alu_op[i]  = ALU_XOR;
                    use_imm[i] = 1'b1;
                end
                // Execute places the immediate at the top for PASSB
                OP_LUI: begin
                    alu_op[i]  = ALU_PASSB;
                    use_imm[i] = 1'b1;
                end
                // NOP and anything undefined
                default: begin
                    has_result[i] = 1'b0;
                end
            endcase

            writes_rd[i] = issue_valid[i] && has_result[i] && (issue_rd[i] != '0);
        end
    end

endmodule

//--- src.f
source/cpu_pkg.sv
source/uop_decode.sv
source/prf.sv
source/alu_execute.sv
source/cdb_result.sv
source/issue_core.sv
dv/issue_core_tb.sv
